// File: build.f
+incdir+include
hw/cmdDecoderPkg.sv
hw/tmrReg.sv
hw/cmdSequencer.sv
hw/cmdDataCapture.sv
hw/cmdErrorCounters.sv
hw/cmdDecoder.sv
sim/cmdDecoderChecker.sv
sim/tb_cmdDecoder.sv

// File: hw/cmdDataCapture.sv
// Shadow shift register, RdReg/WrReg delay, voted Addr, WrRegData and RunMode
`timescale 1ns/10ps
`include "cmdDecoder_params.svh"

module cmdDataCapture (
  input  logic                   CK,
  input  logic                   RESET,
  input  logic                   DCI,
  input  logic                   rdStrobe,
  input  logic                   wrStrobe,
  input  logic                   runSet,
  input  logic                   runClr,
  input  logic                   resetCmd,
  output cmdDecoderPkg::addrT    Addr,
  output cmdDecoderPkg::regDataT WrRegData,
  output logic                   RdReg,
  output logic                   WrReg,
  output logic                   RunMode,
  output logic                   dataSeu
);

  import cmdDecoderPkg::*;

  logic [`CMD_SHADOW_W-1:0] shadow;
  addrT                     addrD;
  regDataT                  dataD;
  logic                     rdDly;
  logic                     wrDly;
  logic                     addrSeu;
  logic                     dataRegSeu;
  logic                     runSeu;

  // --------------------
  // Shadow register
  // --------------------
  // Free running, strobe arrives one bit after the payload ends
  always_ff @(posedge CK) begin
    shadow <= {shadow[`CMD_SHADOW_W-2:0], DCI};
  end

  // Field select, bit 0 is already the next command
  always_comb begin
    addrD = Addr;
    dataD = WrRegData;
    if (rdStrobe) begin
      addrD = shadow[`CMD_ADDR_W:1];
    end else if (wrStrobe) begin
      addrD = shadow[`CMD_SHADOW_W-1 -: `CMD_ADDR_W];
      dataD = shadow[`CMD_DATA_W:1];
    end
  end

  // --------------------
  // Strobe delay
  // --------------------
  // Two stages, Addr and data load with the first
  always_ff @(posedge CK) begin
    if (RESET) begin
      rdDly <= 1'b0;
      wrDly <= 1'b0;
      RdReg <= 1'b0;
      WrReg <= 1'b0;
    end else begin
      rdDly <= rdStrobe;
      wrDly <= wrStrobe;
      RdReg <= rdDly;
      WrReg <= wrDly;
    end
  end

  // --------------------
  // Voted registers
  // --------------------
  tmrReg #(.payloadT(addrT)) addrTmr (
    .CK,
    .clear(RESET | resetCmd),
    .next(addrD),
    .q(Addr),
    .mismatch(addrSeu)
  );

  tmrReg #(.payloadT(regDataT)) dataTmr (
    .CK,
    .clear(RESET | resetCmd),
    .next(dataD),
    .q(WrRegData),
    .mismatch(dataRegSeu)
  );

  // ResetCmd leaves RunMode alone
  tmrReg runTmr (
    .CK,
    .clear(RESET | runClr),
    .next(RunMode | runSet),
    .q(RunMode),
    .mismatch(runSeu)
  );

  assign dataSeu = addrSeu | dataRegSeu | runSeu;

  // Read and write never overlap after the delay
  rdWrExclusive: assert property (@(posedge CK) disable iff (RESET)
    !(RdReg && WrReg));

endmodule

// File: hw/cmdDecoder.sv
// Top level of the command decoder: sequencer, data capture and error counters
`timescale 1ns/10ps
`include "cmdDecoder_params.svh"

module cmdDecoder (
  input  logic                   CK,
  input  logic                   RESET,
  input  logic                   DCI,
  input  logic [`CMD_CHIPID_W-1:0] ChipId,
  output logic                   Trigger,
  output logic                   BCR,
  output logic                   ECR,
  output logic                   CAL,
  output logic                   RdReg,
  output logic                   WrReg,
  output logic                   RunMode,
  output cmdDecoderPkg::addrT    Addr,
  output cmdDecoderPkg::regDataT WrRegData,
  output logic [`CMD_SEU_W+1:0]  CmdErrReg
);

  // Sequencer strobes, one cycle each
  logic rdStrobe;
  logic wrStrobe;
  logic runSet;
  logic runClr;
  logic resetCmd;
  // Error and SEU reports
  logic fastErrSet;
  logic slowErrSet;
  logic seqSeu;
  logic dataSeu;

  // --------------------
  // Blocks
  // --------------------
  cmdSequencer seq (
    .CK, .RESET, .DCI, .ChipId,
    .Trigger, .BCR, .ECR, .CAL,
    .rdStrobe, .wrStrobe, .runSet, .runClr, .resetCmd,
    .fastErrSet, .slowErrSet, .seqSeu
  );

  cmdDataCapture capture (
    .CK, .RESET, .DCI,
    .rdStrobe, .wrStrobe, .runSet, .runClr, .resetCmd,
    .Addr, .WrRegData, .RdReg, .WrReg, .RunMode, .dataSeu
  );

  // ResetCmd clears the error word as well
  cmdErrorCounters errors (
    .CK, .RESET, .resetCmd,
    .fastErrSet, .slowErrSet, .seqSeu, .dataSeu,
    .CmdErrReg
  );

endmodule

// File: hw/cmdDecoderPkg.sv
// Shared types: address, data, counter, shift register, sequencer state and flags
`include "cmdDecoder_params.svh"

package cmdDecoderPkg;

  typedef logic [`CMD_ADDR_W-1:0] addrT;
  typedef logic [`CMD_DATA_W-1:0] regDataT;
  typedef logic [`CMD_CNT_W-1:0] cntT;
  typedef logic [`CMD_SHREG_W-1:0] shRegT;

  // Sequencer phases, idle must stay at zero
  typedef enum logic [2:0] {
    idle,
    fastField,
    slowHdr,
    rdPayload,
    wrPayload,
    runPayload
  } seqStateT;

  // Everything the sequencer keeps in its voted register
  typedef struct packed {
    seqStateT state;
    // Single-cycle pulses
    logic trigger;
    logic bcr;
    logic ecr;
    logic cal;
    logic resetCmd;
    // Error pulses
    logic fastErr;
    logic slowErr;
    // Slow command results
    logic rdReg;
    logic wrReg;
    logic runSet;
    logic runClr;
    // Chip id did not match, payload gets swallowed
    logic foreign;
  } seqRegT;

endpackage

// File: hw/cmdErrorCounters.sv
// Saturating SEU counter, sticky fast and slow error flags, CmdErrReg packing
`timescale 1ns/10ps
`include "cmdDecoder_params.svh"

module cmdErrorCounters (
  input  logic                  CK,
  input  logic                  RESET,
  input  logic                  resetCmd,
  input  logic                  fastErrSet,
  input  logic                  slowErrSet,
  input  logic                  seqSeu,
  input  logic                  dataSeu,
  output logic [`CMD_SEU_W+1:0] CmdErrReg
);

  logic [`CMD_SEU_W-1:0] seuCnt;
  logic                  seuFull;
  logic                  fastErr;
  logic                  slowErr;
  logic                  clearAll;

  assign seuFull = &seuCnt;
  // Either reset source wipes the whole word
  assign clearAll = RESET | resetCmd;

  // --------------------
  // Counter and flags
  // --------------------
  always_ff @(posedge CK) begin
    if (clearAll) begin
      seuCnt <= '0;
      fastErr <= 1'b0;
      slowErr <= 1'b0;
    end else begin
      // One count per cycle with any copy mismatch, stops at full
      if ((seqSeu || dataSeu) && !seuFull) begin
        seuCnt <= seuCnt + 1'b1;
      end
      // Sticky
      if (fastErrSet) begin
        fastErr <= 1'b1;
      end
      if (slowErrSet) begin
        slowErr <= 1'b1;
      end
    end
  end

  // Count on top, then FastErr, SlowErr in bit 0
  assign CmdErrReg = {seuCnt, fastErr, slowErr};

  // Saturated count holds until a clear
  seuSaturates: assert property (@(posedge CK) disable iff (RESET)
    (seuFull && !resetCmd) |=> seuFull);

endmodule

// File: hw/cmdSequencer.sv
// Command shift register, remaining-bit counter and decoding FSM, all triplicated
`timescale 1ns/10ps
`include "cmdDecoder_params.svh"

module cmdSequencer (
  input  logic                     CK,
  input  logic                     RESET,
  input  logic                     DCI,
  input  logic [`CMD_CHIPID_W-1:0] ChipId,
  output logic                     Trigger,
  output logic                     BCR,
  output logic                     ECR,
  output logic                     CAL,
  output logic                     rdStrobe,
  output logic                     wrStrobe,
  output logic                     runSet,
  output logic                     runClr,
  output logic                     resetCmd,
  output logic                     fastErrSet,
  output logic                     slowErrSet,
  output logic                     seqSeu
);

  import cmdDecoderPkg::*;

  seqRegT seqQ;
  seqRegT seqD;
  cntT    cnt;
  cntT    cntD;
  shRegT  shReg;
  shRegT  shRegD;
  logic   cmdDone;
  logic   lastBit;
  logic   idMatch;
  logic   shSeu;
  logic   cntSeu;
  logic   stateSeu;

  // Field fully shifted in when one bit is left on the counter
  assign lastBit = (cnt == cntT'(1));
  // Slow header is chip id then code, id sits above the code
  assign idMatch = (shReg[6:4] == ChipId);

  // --------------------
  // Shift register
  // --------------------
  // Upper seven bits drop at every field boundary
  always_comb begin
    if (cmdDone) begin
      shRegD = shRegT'(DCI);
    end else begin
      shRegD = {shReg[`CMD_SHREG_W-2:0], DCI};
    end
  end

  tmrReg #(.payloadT(shRegT)) shTmr (
    .CK,
    .clear(RESET),
    .next(shRegD),
    .q(shReg),
    .mismatch(shSeu)
  );

  tmrReg #(.payloadT(cntT)) cntTmr (
    .CK,
    .clear(RESET),
    .next(cntD),
    .q(cnt),
    .mismatch(cntSeu)
  );

  tmrReg #(.payloadT(seqRegT)) seqTmr (
    .CK,
    .clear(RESET),
    .next(seqD),
    .q(seqQ),
    .mismatch(stateSeu)
  );

  // --------------------
  // Decode FSM
  // --------------------
  always_comb begin
    // Pulses default low, state and id flag hold
    seqD = '0;
    seqD.state = seqQ.state;
    seqD.foreign = seqQ.foreign;
    // Count down to zero and stay there
    cntD = (cnt != '0) ? cnt - cntT'(1) : cnt;
    cmdDone = 1'b0;
    case (seqQ.state)
      idle: begin
        seqD.foreign = 1'b0;
        if (shReg[4:0] == `CMD_TRIG_HDR) begin
          seqD.trigger = 1'b1;
          cmdDone = 1'b1;
        end else if (shReg[4:0] == `CMD_FAST_HDR) begin
          seqD.state = fastField;
          cntD = cntT'(`CMD_LEN_FIELD);
          cmdDone = 1'b1;
        end
      end
      fastField: begin
        if (lastBit) begin
          cmdDone = 1'b1;
          seqD.state = idle;
          case (shReg[3:0])
            `CMD_F_BCR: seqD.bcr = 1'b1;
            `CMD_F_ECR: seqD.ecr = 1'b1;
            `CMD_F_CAL: seqD.cal = 1'b1;
            `CMD_F_SLOW: begin
              seqD.state = slowHdr;
              cntD = cntT'(`CMD_LEN_SLOWHDR);
            end
            default: seqD.fastErr = 1'b1;
          endcase
        end
      end
      slowHdr: begin
        if (lastBit) begin
          cmdDone = 1'b1;
          seqD.state = idle;
          seqD.foreign = !idMatch;
          case (shReg[3:0])
            `CMD_S_RDREG: begin
              seqD.state = rdPayload;
              cntD = cntT'(`CMD_LEN_RD);
            end
            `CMD_S_WRREG: begin
              seqD.state = wrPayload;
              cntD = cntT'(`CMD_LEN_WR);
            end
            `CMD_S_RUNMODE: begin
              seqD.state = runPayload;
              cntD = cntT'(`CMD_LEN_RUN);
            end
            // No payload, acts right away
            `CMD_S_RESET: seqD.resetCmd = idMatch;
            // Unknown code only flagged for this chip
            default: seqD.slowErr = idMatch;
          endcase
        end
      end
      rdPayload: begin
        if (lastBit) begin
          cmdDone = 1'b1;
          seqD.state = idle;
          seqD.rdReg = !seqQ.foreign;
        end
      end
      wrPayload: begin
        if (lastBit) begin
          cmdDone = 1'b1;
          seqD.state = idle;
          seqD.wrReg = !seqQ.foreign;
        end
      end
      runPayload: begin
        if (lastBit) begin
          cmdDone = 1'b1;
          seqD.state = idle;
          if (shReg[5:0] == `CMD_RUN_ON) begin
            seqD.runSet = !seqQ.foreign;
          end else if (shReg[5:0] == `CMD_RUN_OFF) begin
            seqD.runClr = !seqQ.foreign;
          end else begin
            seqD.slowErr = !seqQ.foreign;
          end
        end
      end
      // Unused encodings fall back to idle
      default: seqD.state = idle;
    endcase
  end

  // --------------------
  // Outputs
  // --------------------
  assign Trigger = seqQ.trigger;
  assign BCR = seqQ.bcr;
  assign ECR = seqQ.ecr;
  assign CAL = seqQ.cal;
  assign rdStrobe = seqQ.rdReg;
  assign wrStrobe = seqQ.wrReg;
  assign runSet = seqQ.runSet;
  assign runClr = seqQ.runClr;
  assign resetCmd = seqQ.resetCmd;
  assign fastErrSet = seqQ.fastErr;
  assign slowErrSet = seqQ.slowErr;
  // Disagreement anywhere in the sequencer copies
  assign seqSeu = shSeu | cntSeu | stateSeu;

  // Fast command pulses exclude each other
  fastOneHot: assert property (@(posedge CK) disable iff (RESET)
    $onehot0({Trigger, BCR, ECR, CAL}));

endmodule

// File: hw/tmrReg.sv
// Triplicated register with bitwise majority vote and copy mismatch flag
`timescale 1ns/10ps

module tmrReg #(
  parameter type payloadT = logic
) (
  input  logic    CK,
  input  logic    clear,
  input  payloadT next,
  output payloadT q,
  output logic    mismatch
);

  // Three independent copies of the same state
  payloadT copyA;
  payloadT copyB;
  payloadT copyC;

  // --------------------
  // Storage
  // --------------------
  always_ff @(posedge CK) begin
    if (clear) begin
      copyA <= '0;
      copyB <= '0;
      copyC <= '0;
    end else begin
      // All copies load the same value, a flipped copy heals here
      copyA <= next;
      copyB <= next;
      copyC <= next;
    end
  end

  // --------------------
  // Vote
  // --------------------
  // Two out of three per bit
  assign q = payloadT'((copyA & copyB) | (copyA & copyC) | (copyB & copyC));

  // Any bit where the copies disagree
  assign mismatch = |((copyA ^ copyB) | (copyB ^ copyC));

endmodule

// File: include/cmdDecoder_params.svh
// Widths, header patterns, field codes and field lengths for the command decoder
`ifndef CMD_DECODER_PARAMS_SVH
`define CMD_DECODER_PARAMS_SVH

// --------------------
// Widths
// --------------------
// Register address
`define CMD_ADDR_W 6
// Write data word
`define CMD_DATA_W 16
// Remaining-bit counter
`define CMD_CNT_W 5
// Command shift register
`define CMD_SHREG_W 8
// Shadow register, address plus data plus one trailing bit
`define CMD_SHADOW_W 23
// Saturating SEU count
`define CMD_SEU_W 6
// Hard-wired chip id
`define CMD_CHIPID_W 3

// --------------------
// Headers and codes
// --------------------
`define CMD_TRIG_HDR 5'b11101
`define CMD_FAST_HDR 5'b10110
// Fast field, one-hot
`define CMD_F_BCR 4'b0001
`define CMD_F_ECR 4'b0010
`define CMD_F_CAL 4'b0100
`define CMD_F_SLOW 4'b1000
// Slow command codes
`define CMD_S_RDREG 4'b0001
`define CMD_S_WRREG 4'b0010
`define CMD_S_RUNMODE 4'b0011
`define CMD_S_RESET 4'b0100
// RunMode payloads
`define CMD_RUN_ON 6'b111000
`define CMD_RUN_OFF 6'b000111

// --------------------
// Bits still to come after each decision point
// --------------------
`define CMD_LEN_FIELD 4
`define CMD_LEN_SLOWHDR 7
`define CMD_LEN_RD 6
`define CMD_LEN_WR 22
`define CMD_LEN_RUN 6

`endif

// File: run_sim.sh
#!/usr/bin/env bash
# Build the command decoder testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
  --top-module tb_cmdDecoder -f build.f || { echo "Verilator build failed"; exit 1; }

simOut="$(./obj_dir/Vtb_cmdDecoder)"
echo "$simOut"

echo "$simOut" | grep -qx "test passed" && exit 0 || exit 1

// File: sim/cmdDecoderChecker.sv
// Monitor for the command decoder: pulse timing, level outputs and SEU count
`timescale 1ns/10ps
`include "cmdDecoder_params.svh"

module cmdDecoderChecker (
  input  logic                   CK,
  input  logic                   RESET,
  input  logic                   Trigger,
  input  logic                   BCR,
  input  logic                   ECR,
  input  logic                   CAL,
  input  logic                   RdReg,
  input  logic                   WrReg,
  input  logic                   RunMode,
  input  cmdDecoderPkg::addrT    Addr,
  input  cmdDecoderPkg::regDataT WrRegData,
  input  logic [`CMD_SEU_W+1:0]  CmdErrReg,
  input  logic                   cmdStrobe,
  input  logic [3:0]             expKind,
  input  cmdDecoderPkg::addrT    expAddr,
  input  cmdDecoderPkg::regDataT expData,
  input  logic                   expRun,
  input  logic [`CMD_SEU_W+1:0]  expErr,
  output int                     errorCount,
  output int                     checkCount,
  output int                     doneCount
);

  import cmdDecoderPkg::*;

  // Command kinds as coded in the data file
  localparam logic [3:0] KIND_TRIG = 4'h1;
  localparam logic [3:0] KIND_BCR = 4'h2;
  localparam logic [3:0] KIND_ECR = 4'h3;
  localparam logic [3:0] KIND_CAL = 4'h4;
  localparam logic [3:0] KIND_RD = 4'h5;
  localparam logic [3:0] KIND_WR = 4'h6;
  // Age 0 is the cycle after the last bit was sampled
  localparam int FAST_AGE = 1;
  localparam int SLOW_AGE = 3;
  localparam int LEVEL_AGE = 4;
  localparam int AGE_MAX = 15;

  logic [3:0]            kind;
  addrT                  wantAddr;
  regDataT               wantData;
  logic                  wantRun;
  logic [`CMD_SEU_W+1:0] wantErr;
  int                    age;
  logic                  loaded;
  logic                  afterReset;

  task automatic comparePulse(input string name, input logic seen, input logic want);
    checkCount++;
    if (seen && !want) begin
      $display("Unexpected %s pulse at %0t", name, $time);
      errorCount++;
    end else if (!seen && want) begin
      $display("Missing %s pulse at %0t", name, $time);
      errorCount++;
    end
  endtask

  task automatic compareValue(input string name, input logic [31:0] got,
                              input logic [31:0] want);
    checkCount++;
    if (got !== want) begin
      $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h at %0t", name, got, want, $time);
      errorCount++;
    end
  endtask

  // --------------------
  // Sampling on the falling edge
  // --------------------
  always @(negedge CK) begin
    if (RESET) begin
      loaded = 1'b0;
      age = AGE_MAX;
      afterReset = 1'b1;
      errorCount = 0;
      checkCount = 0;
      doneCount = 0;
    end else begin
      // Everything cleared by reset
      if (afterReset) begin
        compareValue("Addr", 32'(Addr), 32'd0);
        compareValue("WrRegData", 32'(WrRegData), 32'd0);
        compareValue("RunMode", 32'(RunMode), 32'd0);
        compareValue("CmdErrReg", 32'(CmdErrReg), 32'd0);
        afterReset = 1'b0;
      end
      if (cmdStrobe) begin
        kind = expKind;
        wantAddr = expAddr;
        wantData = expData;
        wantRun = expRun;
        wantErr = expErr;
        age = 0;
        loaded = 1'b1;
      end else if (age < AGE_MAX) begin
        age++;
      end
      // Each strobe only in its own slot
      comparePulse("Trigger", Trigger, loaded && kind == KIND_TRIG && age == FAST_AGE);
      comparePulse("BCR", BCR, loaded && kind == KIND_BCR && age == FAST_AGE);
      comparePulse("ECR", ECR, loaded && kind == KIND_ECR && age == FAST_AGE);
      comparePulse("CAL", CAL, loaded && kind == KIND_CAL && age == FAST_AGE);
      comparePulse("RdReg", RdReg, loaded && kind == KIND_RD && age == SLOW_AGE);
      comparePulse("WrReg", WrReg, loaded && kind == KIND_WR && age == SLOW_AGE);
      // No SEU in a clean run
      compareValue("SEU count", 32'(CmdErrReg[`CMD_SEU_W+1:2]), 32'd0);
      if (loaded && age == LEVEL_AGE) begin
        compareValue("Addr", 32'(Addr), 32'(wantAddr));
        compareValue("WrRegData", 32'(WrRegData), 32'(wantData));
        compareValue("RunMode", 32'(RunMode), 32'(wantRun));
        compareValue("CmdErrReg", 32'(CmdErrReg), 32'(wantErr));
        doneCount++;
      end
    end
  end

endmodule

// File: sim/cmdDecoder_testdata.txt
// kind, bit count (hex), bits (hex, msb first), then expected Addr, WrRegData, RunMode, CmdErrReg
// kind 0 no pulse, 1 Trigger, 2 BCR, 3 ECR, 4 CAL, 5 RdReg, 6 WrReg, f end of list
1 05 000000001d 00 0000 0 00
2 09 0000000161 00 0000 0 00
3 09 0000000162 00 0000 0 00
4 09 0000000164 00 0000 0 00
6 26 2d1495beef 15 beef 0 00 // write 0x15 <- 0xbeef
5 16 00002d146a 2a beef 0 00 // read 0x2a
0 16 00002d14f8 2a beef 1 00 // run on
1 05 000000001d 2a beef 1 00
0 16 00002d14ea 2a beef 1 01 // bad run payload
0 26 2d08bf1234 2a beef 1 01 // foreign id from here
0 16 00002d08c7 2a beef 1 01
0 10 000000b424 2a beef 1 01
0 16 00002d0841 2a beef 1 01
0 10 000000b42f 2a beef 1 01
0 09 0000000163 2a beef 1 03 // fast field 0011
0 10 000000b459 2a beef 1 03 // slow code 9
0 10 000000b454 00 0000 1 00 // ResetCmd
6 26 2d14818001 01 8001 1 00
0 16 00002d14c7 01 8001 0 00 // run off
0 09 0000000160 01 8001 0 02
5 16 00002d147f 3f 8001 0 02
6 26 2d14aa5a5a 2a 5a5a 0 02
4 09 0000000164 2a 5a5a 0 02
0 16 00002d14f8 2a 5a5a 1 02
1 05 000000001d 2a 5a5a 1 02
f 00 0000000000 00 0000 0 00

// File: sim/tb_cmdDecoder.sv
// Testbench top: clock, reset, test data reader, DCI driver and watchdog
`timescale 1ns/10ps
`include "cmdDecoder_params.svh"

module tb_cmdDecoder;

  import cmdDecoderPkg::*;

  // Words per command line in the data file
  localparam int FIELDS = 7;
  localparam int MEM_DEPTH = 256;
  localparam logic [3:0] KIND_END = 4'hf;
  localparam logic [`CMD_CHIPID_W-1:0] OWN_ID = 3'b101;
  localparam int CK_PERIOD = 4;
  localparam int RESET_CYCLES = 4;
  localparam int GAP_MAX = 12;
  localparam int MARGIN = 40;

  logic                   CK;
  logic                   RESET;
  logic                   DCI;
  logic [`CMD_CHIPID_W-1:0] ChipId;
  logic                   Trigger;
  logic                   BCR;
  logic                   ECR;
  logic                   CAL;
  logic                   RdReg;
  logic                   WrReg;
  logic                   RunMode;
  addrT                   Addr;
  regDataT                WrRegData;
  logic [`CMD_SEU_W+1:0]  CmdErrReg;

  // Expectations handed to the monitor
  logic                   cmdStrobe;
  logic [3:0]             expKind;
  addrT                   expAddr;
  regDataT                expData;
  logic                   expRun;
  logic [`CMD_SEU_W+1:0]  expErr;
  int                     errorCount;
  int                     checkCount;
  int                     doneCount;

  // Staged for the edge after the last bit
  logic                   strobeNext;
  logic [63:0]            testMem [0:MEM_DEPTH-1];
  int                     cmdCount;
  int                     watchdogCycles;
  logic                   limitReady;

  cmdDecoder u_dut (
    .CK, .RESET, .DCI, .ChipId,
    .Trigger, .BCR, .ECR, .CAL, .RdReg, .WrReg, .RunMode,
    .Addr, .WrRegData, .CmdErrReg
  );

  cmdDecoderChecker monitor (
    .CK, .RESET,
    .Trigger, .BCR, .ECR, .CAL, .RdReg, .WrReg, .RunMode,
    .Addr, .WrRegData, .CmdErrReg,
    .cmdStrobe, .expKind, .expAddr, .expData, .expRun, .expErr,
    .errorCount, .checkCount, .doneCount
  );

  initial begin
    CK = 1'b0;
    forever #(CK_PERIOD / 2) CK = ~CK;
  end

  // One bit per edge, strobe rides along when staged
  task automatic driveBit(input logic value);
    @(posedge CK);
    DCI <= value;
    cmdStrobe <= strobeNext;
    strobeNext = 1'b0;
  endtask

  // --------------------
  // Stimulus
  // --------------------
  initial begin
    int i;
    int b;
    int base;
    int gap;
    int nBits;
    logic [63:0] bits;
    RESET = 1'b1;
    DCI = 1'b0;
    ChipId = OWN_ID;
    cmdStrobe = 1'b0;
    expKind = '0;
    expAddr = '0;
    expData = '0;
    expRun = 1'b0;
    expErr = '0;
    strobeNext = 1'b0;
    limitReady = 1'b0;
    void'($urandom(32'ha5ac));
    $readmemh("sim/cmdDecoder_testdata.txt", testMem);
    // Command count and worst-case run length
    cmdCount = 0;
    watchdogCycles = RESET_CYCLES + MARGIN;
    while ((cmdCount + 1) * FIELDS <= MEM_DEPTH &&
           testMem[cmdCount * FIELDS][3:0] !== KIND_END) begin
      watchdogCycles += int'(testMem[cmdCount * FIELDS + 1]) + GAP_MAX;
      cmdCount++;
    end
    limitReady = 1'b1;
    repeat (RESET_CYCLES) @(posedge CK);
    RESET <= 1'b0;
    for (i = 0; i < cmdCount; i++) begin
      base = i * FIELDS;
      // Every third command follows with no gap
      gap = (i % 3 == 2) ? 0 : int'($urandom % (GAP_MAX + 1));
      repeat (gap) driveBit(1'b0);
      nBits = int'(testMem[base + 1]);
      bits = testMem[base + 2];
      for (b = nBits - 1; b >= 0; b--) begin
        driveBit(bits[b]);
      end
      expKind <= testMem[base][3:0];
      expAddr <= addrT'(testMem[base + 3]);
      expData <= regDataT'(testMem[base + 4]);
      expRun <= testMem[base + 5][0];
      expErr <= testMem[base + 6][`CMD_SEU_W+1:0];
      strobeNext = 1'b1;
    end
    // Idle line until the monitor has checked every command
    while (doneCount != cmdCount) driveBit(1'b0);
    $display("Commands: %0d, checks: %0d, errors: %0d", cmdCount, checkCount, errorCount);
    if (errorCount == 0 && cmdCount != 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // --------------------
  // Watchdog
  // --------------------
  initial begin
    wait (limitReady);
    #(watchdogCycles * CK_PERIOD);
    $display("Watchdog expired with %0d of %0d commands checked", doneCount, cmdCount);
    $display("Commands: %0d, checks: %0d, errors: %0d", cmdCount, checkCount, errorCount);
    $display("test failed");
    $finish;
  end

endmodule
